// ==== sim.f ====
isa_pkg.sv
issue_pkg.sv
reg_file.sv
scoreboard.sv
issue_stage.sv
issue_top.sv
issue_asserts.sv
tb_issue.sv

// ==== Makefile ====
sim:
	verilator --binary --timing --assert -f sim.f --top-module tb_issue
	out="$$(./obj_dir/Vtb_issue)"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== tb_issue.sv ====
`default_nettype none

module tb_issue;
    timeunit 1ns;
    timeprecision 100ps;

    localparam issue_pkg::row_t alu_lat = 3'd1;
    localparam issue_pkg::row_t mem_lat = 3'd2;
    localparam issue_pkg::row_t mul_lat = 3'd4;

    // Stimulus modes
    localparam int mode_read   = 0;
    localparam int mode_mix    = 1;
    localparam int mode_unit   = 2;
    localparam int mode_hazard = 3;
    localparam int mode_zero   = 4;
    localparam int mode_idle   = 5;

    // Test lengths in cycles and the idle cycles after each test
    localparam int len_read    = 32;
    localparam int len_mix     = 1200;
    localparam int len_unit    = 400;
    localparam int len_hazard  = 300;
    localparam int len_zero    = 200;
    localparam int drain       = 6;
    localparam int cycle_limit =
        2 * (3 + len_read + len_mix + len_unit + len_hazard + len_zero + 5 * drain);

    logic                 clock;
    logic                 reset;
    issue_pkg::id_issue_t id;
    logic                 id_valid;
    logic                 stall;
    issue_pkg::wb_t       wb;
    issue_pkg::issue_ex_t ex;
    logic                 ex_valid;

    // Reference model state
    isa_pkg::word_t       model_regs [32];
    issue_pkg::row_t      model_rows [32];
    issue_pkg::issue_ex_t expected_q [$];
    logic                 held;
    int                   errors;
    int                   checks;
    int                   cycle_count;

    issue_top #(
        .alu_latency (alu_lat),
        .mem_latency (mem_lat),
        .mul_latency (mul_lat)
    ) i_issue_top (
        .clock    (clock),
        .reset    (reset),
        .id       (id),
        .id_valid (id_valid),
        .stall    (stall),
        .wb       (wb),
        .ex       (ex),
        .ex_valid (ex_valid)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Error: %0t ns: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    function automatic issue_pkg::unit_t unit_for(isa_pkg::opcode_t op, isa_pkg::funct_t funct);
        if ((op == isa_pkg::op_lw) || (op == isa_pkg::op_sw))
            return issue_pkg::unit_mem;
        if ((op == isa_pkg::op_special) && (funct == isa_pkg::funct_mult))
            return issue_pkg::unit_mul;
        return issue_pkg::unit_alu;
    endfunction

    function automatic issue_pkg::row_t latency_of(issue_pkg::unit_t u);
        if (u == issue_pkg::unit_mem)
            return mem_lat;
        if (u == issue_pkg::unit_mul)
            return mul_lat;
        return alu_lat;
    endfunction

    // Control fields with dest and write_reg as one value for comparison
    function automatic logic [17:0] ctrl_bits(issue_pkg::issue_ex_t x);
        return {x.aluop, x.sel_alu_shift, x.sel_imm_b, x.unsig, x.shift_op, x.read_mem,
                x.write_mem, x.sel_w_source, x.write_ov, x.dest, x.write_reg};
    endfunction

    // Mostly registers 0 to 3 so that hazards are frequent
    function automatic isa_pkg::reg_addr_t pick_reg();
        if ($urandom_range(0, 9) < 7)
            return isa_pkg::reg_addr_t'($urandom_range(0, 3));
        return isa_pkg::reg_addr_t'($urandom);
    endfunction

    function automatic issue_pkg::id_issue_t gen_instr(int mode, int idx);
        issue_pkg::id_issue_t d;
        logic [95:0]          bits;
        int                   pick;
        bits = {$urandom, $urandom, $urandom};
        d = bits[$bits(d)-1:0];
        pick = $urandom_range(0, 7);
        if (pick == 0) begin
            d.op = isa_pkg::op_lw;
        end else if (pick == 1) begin
            d.op = isa_pkg::op_sw;
        end else if (pick < 4) begin
            d.op = isa_pkg::op_special;
            if ($urandom_range(0, 1) == 1)
                d.funct = isa_pkg::funct_mult;
        end
        d.addr_a = pick_reg();
        d.addr_b = pick_reg();
        d.dest   = pick_reg();
        case (mode)
            mode_read: begin
                d.addr_a    = isa_pkg::reg_addr_t'(idx);
                d.addr_b    = isa_pkg::reg_addr_t'(31 - idx);
                d.write_reg = 1'b0;
            end
            mode_unit: begin
                d.addr_a = isa_pkg::reg_addr_t'($urandom);
                d.addr_b = isa_pkg::reg_addr_t'($urandom);
                d.dest   = isa_pkg::reg_addr_t'($urandom);
            end
            mode_hazard: begin
                d.addr_a    = isa_pkg::reg_addr_t'($urandom_range(1, 3));
                d.addr_b    = isa_pkg::reg_addr_t'($urandom_range(1, 3));
                d.dest      = isa_pkg::reg_addr_t'($urandom_range(1, 3));
                d.write_reg = 1'b1;
            end
            mode_zero: begin
                if ($urandom_range(0, 1) == 1)
                    d.dest = '0;
                d.write_reg = 1'b1;
            end
            default: ;
        endcase
        return d;
    endfunction

    // Checks the last edge, drives the inputs and predicts the next edge
    task automatic step(input int mode, input int idx);
        issue_pkg::issue_ex_t want;
        logic                 stall_want;
        logic                 load_row;
        @(negedge clock);
        if (expected_q.size() > 0) begin
            want = expected_q.pop_front();
            check_value("ex_valid", 32'(ex_valid), 32'd1);
            check_value("control", 32'(ctrl_bits(ex)), 32'(ctrl_bits(want)));
            check_value("imm", ex.imm, want.imm);
            check_value("rega", ex.rega, want.rega);
            check_value("regb", ex.regb, want.regb);
            check_value("shamt", 32'(ex.shamt), 32'(want.shamt));
            check_value("unit", 32'(ex.unit), 32'(want.unit));
        end else begin
            check_value("ex_valid", 32'(ex_valid), 32'd0);
            check_value("unit", 32'(ex.unit), 32'(issue_pkg::unit_none));
        end
        // Decode holds a stalled instruction
        if (!held) begin
            id_valid = (mode == mode_read) || ((mode != mode_idle) && ($urandom_range(0, 3) != 0));
            id = gen_instr(mode, idx);
        end
        wb = '0;
        if ((mode != mode_read) && ($urandom_range(0, 9) < 3)) begin
            wb.enable = 1'b1;
            wb.addr   = pick_reg();
            wb.data   = $urandom;
        end
        #1;
        stall_want = id_valid && ((model_rows[id.addr_a] != '0) ||
                                  (id.uses_b && (model_rows[id.addr_b] != '0)));
        check_value("stall", 32'(stall), 32'(stall_want));
        if (id_valid && !stall_want) begin
            want.aluop         = id.aluop;
            want.sel_alu_shift = id.sel_alu_shift;
            want.sel_imm_b     = id.sel_imm_b;
            want.unsig         = id.unsig;
            want.shift_op      = id.shift_op;
            want.read_mem      = id.read_mem;
            want.write_mem     = id.write_mem;
            want.sel_w_source  = id.sel_w_source;
            want.write_ov      = id.write_ov;
            want.dest          = id.dest;
            want.write_reg     = id.write_reg;
            want.imm           = id.imm;
            want.rega          = model_regs[id.addr_a];
            want.regb          = model_regs[id.addr_b];
            want.shamt         = want.rega[4:0];
            want.unit          = unit_for(id.op, id.funct);
            expected_q.push_back(want);
        end
        load_row = id_valid && !stall_want && id.write_reg && (id.dest != '0);
        for (int i = 0; i < 32; i++) begin
            if (load_row && (id.dest == isa_pkg::reg_addr_t'(i)))
                model_rows[i] = latency_of(unit_for(id.op, id.funct));
            else if (model_rows[i] != '0)
                model_rows[i] = model_rows[i] - 3'd1;
        end
        if (wb.enable && (wb.addr != '0))
            model_regs[wb.addr] = wb.data;
        held = stall_want;
    endtask

    task automatic run_test(input string name, input int mode, input int cycles);
        int errors_before;
        errors_before = errors;
        for (int n = 0; n < cycles; n++)
            step(mode, n);
        repeat (drain) step(mode_idle, 0);
        $display("%s: %s", name, (errors == errors_before) ? "ok" : "mismatches");
    endtask

    initial begin
        void'($urandom(32'h8ac46f88));
        reset    = 1'b0;
        id       = '0;
        id_valid = 1'b0;
        wb       = '0;
        held     = 1'b0;
        errors   = 0;
        checks   = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
            model_rows[i] = '0;
        end
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
        #1;
        check_value("ex_valid", 32'(ex_valid), 32'd0);
        check_value("unit", 32'(ex.unit), 32'(issue_pkg::unit_none));
        check_value("stall", 32'(stall), 32'd0);
        $display("reset: %s", (errors == 0) ? "ok" : "mismatches");
        run_test("read after reset", mode_read, len_read);
        run_test("random mix", mode_mix, len_mix);
        run_test("unit select", mode_unit, len_unit);
        run_test("hazard stalls", mode_hazard, len_hazard);
        run_test("zero dest and uses_b", mode_zero, len_zero);
        errors += i_issue_top.i_issue_stage.i_issue_asserts.failures;
        $display("Summary: 6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== issue_asserts.sv ====
`default_nettype none

// Output protocol of the issue stage
module issue_asserts (
    input logic                 clock,
    input logic                 reset,
    input issue_pkg::id_issue_t id,
    input logic                 id_valid,
    input logic                 stall,
    input logic                 ex_valid,
    input issue_pkg::issue_ex_t ex
);
    timeunit 1ns;
    timeprecision 100ps;

    int failures = 0;

    // A stalled cycle leaves a bubble behind
    bubble_after_stall: assert property (
        @(posedge clock) disable iff (!reset) stall |=> !ex_valid
    ) else begin
        $error("ex_valid set in the cycle after a stall");
        failures++;
    end

    // An empty slot carries no unit
    empty_slot_unit: assert property (
        @(posedge clock) disable iff (!reset) !ex_valid |-> (ex.unit == issue_pkg::unit_none)
    ) else begin
        $error("ex.unit is not unit_none while ex_valid is low");
        failures++;
    end

    // Decode keeps offering a stalled instruction unchanged
    stalled_instr_held: assert property (
        @(posedge clock) disable iff (!reset) stall |=> (id_valid && $stable(id))
    ) else begin
        $error("decode dropped or changed a stalled instruction");
        failures++;
    end

endmodule

bind issue_stage issue_asserts i_issue_asserts (
    .clock    (clock),
    .reset    (reset),
    .id       (id),
    .id_valid (id_valid),
    .stall    (stall),
    .ex_valid (ex_valid),
    .ex       (ex)
);

`default_nettype wire

// ==== issue_top.sv ====
`default_nettype none

// Issue stage with its register file and scoreboard
module issue_top #(
    parameter issue_pkg::row_t alu_latency = 3'd1,
    parameter issue_pkg::row_t mem_latency = 3'd2,
    parameter issue_pkg::row_t mul_latency = 3'd4
) (
    input  logic                 clock,
    input  logic                 reset,

    // Decode side
    input  issue_pkg::id_issue_t id,
    input  logic                 id_valid,
    output logic                 stall,

    // Writeback into the register file
    input  issue_pkg::wb_t       wb,

    // Execute side
    output issue_pkg::issue_ex_t ex,
    output logic                 ex_valid
);

    isa_pkg::reg_addr_t rf_addr_a;
    isa_pkg::reg_addr_t rf_addr_b;
    isa_pkg::word_t     rf_data_a;
    isa_pkg::word_t     rf_data_b;
    logic               pending_a;
    logic               pending_b;
    logic               issue;
    isa_pkg::reg_addr_t issue_dest;
    logic               issue_write;
    issue_pkg::unit_t   issue_unit;

    reg_file i_reg_file (
        .clock  (clock),
        .reset  (reset),
        .addr_a (rf_addr_a),
        .addr_b (rf_addr_b),
        .data_a (rf_data_a),
        .data_b (rf_data_b),
        .wb     (wb)
    );

    // Same source addresses go to the register file and the scoreboard
    scoreboard #(
        .alu_latency (alu_latency),
        .mem_latency (mem_latency),
        .mul_latency (mul_latency)
    ) i_scoreboard (
        .clock       (clock),
        .reset       (reset),
        .addr_a      (rf_addr_a),
        .addr_b      (rf_addr_b),
        .pending_a   (pending_a),
        .pending_b   (pending_b),
        .issue       (issue),
        .issue_dest  (issue_dest),
        .issue_write (issue_write),
        .issue_unit  (issue_unit)
    );

    issue_stage i_issue_stage (
        .clock       (clock),
        .reset       (reset),
        .id          (id),
        .id_valid    (id_valid),
        .stall       (stall),
        .rf_addr_a   (rf_addr_a),
        .rf_addr_b   (rf_addr_b),
        .rf_data_a   (rf_data_a),
        .rf_data_b   (rf_data_b),
        .pending_a   (pending_a),
        .pending_b   (pending_b),
        .issue       (issue),
        .issue_dest  (issue_dest),
        .issue_write (issue_write),
        .issue_unit  (issue_unit),
        .ex          (ex),
        .ex_valid    (ex_valid)
    );

endmodule

`default_nettype wire

// ==== issue_stage.sv ====
`default_nettype none

// Hazard check, unit selection and the register toward execute
module issue_stage (
    input  logic                  clock,
    input  logic                  reset,

    // From decode
    input  issue_pkg::id_issue_t  id,
    input  logic                  id_valid,
    output logic                  stall,

    // Register file read ports
    output isa_pkg::reg_addr_t    rf_addr_a,
    output isa_pkg::reg_addr_t    rf_addr_b,
    input  isa_pkg::word_t        rf_data_a,
    input  isa_pkg::word_t        rf_data_b,

    // Scoreboard lookup and update
    input  logic                  pending_a,
    input  logic                  pending_b,
    output logic                  issue,
    output isa_pkg::reg_addr_t    issue_dest,
    output logic                  issue_write,
    output issue_pkg::unit_t      issue_unit,

    // Toward execute
    output issue_pkg::issue_ex_t  ex,
    output logic                  ex_valid
);

    issue_pkg::unit_t     sel_unit;
    issue_pkg::issue_ex_t ex_next;
    logic                 accept;

    // Second source only matters when the instruction reads it
    assign stall  = id_valid && (pending_a || (id.uses_b && pending_b));
    assign accept = id_valid && !stall;

    assign rf_addr_a = id.addr_a;
    assign rf_addr_b = id.addr_b;

    // Loads and stores to memory, mult to multiply, the rest to the ALU
    always_comb begin
        if ((id.op == isa_pkg::op_lw) || (id.op == isa_pkg::op_sw)) begin
            sel_unit = issue_pkg::unit_mem;
        end else if ((id.op == isa_pkg::op_special) && (id.funct == isa_pkg::funct_mult)) begin
            sel_unit = issue_pkg::unit_mul;
        end else begin
            sel_unit = issue_pkg::unit_alu;
        end
    end

    // Scoreboard update for the instruction leaving this cycle
    assign issue       = accept;
    assign issue_dest  = id.dest;
    assign issue_write = id.write_reg;
    assign issue_unit  = sel_unit;

    always_comb begin
        ex_next.aluop         = id.aluop;
        ex_next.sel_alu_shift = id.sel_alu_shift;
        ex_next.sel_imm_b     = id.sel_imm_b;
        ex_next.unsig         = id.unsig;
        ex_next.shift_op      = id.shift_op;
        ex_next.read_mem      = id.read_mem;
        ex_next.write_mem     = id.write_mem;
        ex_next.sel_w_source  = id.sel_w_source;
        ex_next.write_ov      = id.write_ov;
        ex_next.dest          = id.dest;
        ex_next.write_reg     = id.write_reg;
        ex_next.imm           = id.imm;
        ex_next.rega          = rf_data_a;
        ex_next.regb          = rf_data_b;
        ex_next.shamt         = rf_data_a[isa_pkg::shamt_width-1:0];
        ex_next.unit          = sel_unit;
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            ex       <= '0;
            ex.unit  <= issue_pkg::unit_none;
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= accept;
            if (accept) begin
                ex <= ex_next;
            end else begin
                // A bubble leaves the payload as it was
                ex.unit <= issue_pkg::unit_none;
            end
        end
    end

endmodule

`default_nettype wire

// ==== scoreboard.sv ====
`default_nettype none

// Tracks results still in flight, one countdown row per register
module scoreboard #(
    parameter issue_pkg::row_t alu_latency = 3'd1,
    parameter issue_pkg::row_t mem_latency = 3'd2,
    parameter issue_pkg::row_t mul_latency = 3'd4
) (
    input  logic               clock,
    input  logic               reset,

    // Source lookups for the instruction waiting in issue
    input  isa_pkg::reg_addr_t addr_a,
    input  isa_pkg::reg_addr_t addr_b,
    output logic               pending_a,
    output logic               pending_b,

    // Issue strobe with the destination of the accepted instruction
    input  logic               issue,
    input  isa_pkg::reg_addr_t issue_dest,
    input  logic               issue_write,
    input  issue_pkg::unit_t   issue_unit
);

    issue_pkg::row_t rows [isa_pkg::num_regs];

    issue_pkg::row_t load_value;
    logic            load_en;

    // Latency of the unit the new instruction goes to
    always_comb begin
        case (issue_unit)
            issue_pkg::unit_alu: load_value = alu_latency;
            issue_pkg::unit_mem: load_value = mem_latency;
            issue_pkg::unit_mul: load_value = mul_latency;
            default:             load_value = '0;
        endcase
    end

    // Register zero never gets a row loaded
    assign load_en = issue && issue_write && (issue_dest != '0);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < isa_pkg::num_regs; i++) begin
                rows[i] <= '0;
            end
        end else begin
            for (int i = 0; i < isa_pkg::num_regs; i++) begin
                // A new issue overwrites a row that is still counting
                if (load_en && (issue_dest == isa_pkg::reg_addr_t'(i))) begin
                    rows[i] <= load_value;
                end else if (rows[i] != '0) begin
                    rows[i] <= rows[i] - 1'b1;
                end
            end
        end
    end

    // Row zero stays clear, so register zero is never pending
    assign pending_a = (rows[addr_a] != '0);
    assign pending_b = (rows[addr_b] != '0);

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`default_nettype none

// Architectural register file
// Two combinational read ports, one write port from writeback
module reg_file (
    input  logic               clock,
    input  logic               reset,
    input  isa_pkg::reg_addr_t addr_a,
    input  isa_pkg::reg_addr_t addr_b,
    output isa_pkg::word_t     data_a,
    output isa_pkg::word_t     data_b,
    input  issue_pkg::wb_t     wb
);

    isa_pkg::word_t regs [isa_pkg::num_regs];

    logic write_en;

    // Writes to register zero are dropped
    assign write_en = wb.enable && (wb.addr != '0);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < isa_pkg::num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // A write in this cycle shows up only after the edge
    always_comb begin
        if (addr_a == '0) begin
            data_a = '0;
        end else begin
            data_a = regs[addr_a];
        end
        if (addr_b == '0) begin
            data_b = '0;
        end else begin
            data_b = regs[addr_b];
        end
    end

endmodule

`default_nettype wire

// ==== issue_pkg.sv ====
`default_nettype none

// Types shared between decode, issue, the scoreboard and execute
package issue_pkg;

    // Functional unit chosen for an instruction
    // unit_none marks an empty slot toward execute
    typedef enum logic [1:0] {
        unit_alu  = 2'b00,
        unit_mem  = 2'b01,
        unit_mul  = 2'b10,
        unit_none = 2'b11
    } unit_t;

    // Cycles left until a register result is written
    typedef logic [2:0] row_t;

    // Instruction as handed over by decode
    typedef struct packed {
        isa_pkg::opcode_t  op;
        isa_pkg::funct_t   funct;
        isa_pkg::reg_addr_t addr_a;
        isa_pkg::reg_addr_t addr_b;
        logic              uses_b;
        isa_pkg::reg_addr_t dest;
        logic              write_reg;
        isa_pkg::word_t    imm;
        logic [2:0]        aluop;
        logic              sel_alu_shift;
        logic              sel_imm_b;
        logic              unsig;
        logic [1:0]        shift_op;
        logic              read_mem;
        logic              write_mem;
        logic              sel_w_source;
        logic              write_ov;
    } id_issue_t;

    // Instruction and its operands on the way to execute
    typedef struct packed {
        logic [2:0]        aluop;
        logic              sel_alu_shift;
        logic              sel_imm_b;
        logic              unsig;
        logic [1:0]        shift_op;
        logic              read_mem;
        logic              write_mem;
        logic              sel_w_source;
        logic              write_ov;
        isa_pkg::reg_addr_t dest;
        logic              write_reg;
        isa_pkg::word_t    imm;
        isa_pkg::word_t    rega;
        isa_pkg::word_t    regb;
        isa_pkg::shamt_t   shamt;
        unit_t             unit;
    } issue_ex_t;

    // Register file write from writeback
    typedef struct packed {
        logic              enable;
        isa_pkg::reg_addr_t addr;
        isa_pkg::word_t    data;
    } wb_t;

endpackage

`default_nettype wire

// ==== isa_pkg.sv ====
`default_nettype none

// Constants of the MIPS-style instruction set used by the issue stage
package isa_pkg;

    // Register file geometry
    localparam int reg_addr_width = 5;
    localparam int num_regs       = 32;

    // Datapath width
    localparam int word_width = 32;

    // Shift amount comes from the low bits of the first operand
    localparam int shamt_width = 5;

    // Primary opcode and function field widths
    localparam int op_width    = 6;
    localparam int funct_width = 6;

    typedef logic [reg_addr_width-1:0] reg_addr_t;
    typedef logic [word_width-1:0]     word_t;
    typedef logic [shamt_width-1:0]    shamt_t;
    typedef logic [op_width-1:0]       opcode_t;
    typedef logic [funct_width-1:0]    funct_t;

    // R-type instructions are decoded further by the function field
    localparam opcode_t op_special = 6'b000000;

    // Memory access opcodes
    localparam opcode_t op_lw = 6'b100011;
    localparam opcode_t op_sw = 6'b101011;

    // Function code of the multiply instruction under op_special
    localparam funct_t funct_mult = 6'b011000;

endpackage

`default_nettype wire
